/* filelist.f */
logic/hdc_dims_pkg.sv
logic/class_gen_ctrl_pkg.sv
logic/class_fsm.sv
logic/chunk_class_counter.sv
logic/class_bundler.sv
logic/class_thresholder.sv
logic/nonbinary_class_reg.sv
logic/binary_class_reg.sv
logic/class_hv_gen_top.sv
testbench/class_hv_gen_assert.sv
testbench/class_hv_gen_tb.sv

/* testbench/class_hv_gen_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module class_hv_gen_tb;

    typedef logic [hdc_dims_pkg::NUM_CLASSES-1:0][hdc_dims_pkg::HV_DIM-1:0] class_hvs_t;

    localparam int ACC_LATENCY = hdc_dims_pkg::SEQ_CYCLE_COUNT + 1;
    localparam int BIN_LATENCY = hdc_dims_pkg::NUM_CLASSES * hdc_dims_pkg::SEQ_CYCLE_COUNT + 1;
    localparam int DIM_MAX     = (1 << hdc_dims_pkg::BITWIDTH_PER_DIM) - 1;
    localparam int SAMPLE_MAX  = (1 << hdc_dims_pkg::SAMPLE_CNT_W) - 1;
    // roughly four times the full run of directed tests
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic nrst;
    logic en;
    logic start_class_gen;
    logic training_hdc_model;
    logic training_dataset_finished;
    logic [hdc_dims_pkg::HV_DIM-1:0] encoded_hv;
    logic [hdc_dims_pkg::CLASS_SEL_W-1:0] class_select_bits;
    class_hvs_t bin_class_hvs;
    logic class_gen_done;

    // reference model
    int ref_counts [hdc_dims_pkg::NUM_CLASSES][hdc_dims_pkg::HV_DIM];
    int ref_samples [hdc_dims_pkg::NUM_CLASSES];

    integer seed;
    int cycle_count;
    int value_errors;
    int other_errors;

    class_hv_gen_top DUT (
        .clk                       (clk),
        .nrst                      (nrst),
        .en                        (en),
        .start_class_gen           (start_class_gen),
        .training_hdc_model        (training_hdc_model),
        .training_dataset_finished (training_dataset_finished),
        .encoded_hv                (encoded_hv),
        .class_select_bits         (class_select_bits),
        .bin_class_hvs             (bin_class_hvs),
        .class_gen_done            (class_gen_done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without reaching the end", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [hdc_dims_pkg::HV_DIM-1:0] random_hv();
        logic [hdc_dims_pkg::HV_DIM-1:0] hv;
        for (int i = 0; i < hdc_dims_pkg::HV_DIM; i += 32) begin
            hv[i +: 32] = $random(seed);
        end
        return hv;
    endfunction

    function automatic void model_clear();
        for (int c = 0; c < hdc_dims_pkg::NUM_CLASSES; c++) begin
            ref_samples[c] = 0;
            for (int d = 0; d < hdc_dims_pkg::HV_DIM; d++) begin
                ref_counts[c][d] = 0;
            end
        end
    endfunction

    function automatic void model_bundle(logic [hdc_dims_pkg::HV_DIM-1:0] hv, int cls);
        for (int d = 0; d < hdc_dims_pkg::HV_DIM; d++) begin
            if (hv[d] && ref_counts[cls][d] < DIM_MAX) begin
                ref_counts[cls][d]++;
            end
        end
        if (ref_samples[cls] < SAMPLE_MAX) begin
            ref_samples[cls]++;
        end
    endfunction

    // strict majority, ties and empty classes give zero
    function automatic class_hvs_t expected_hvs();
        class_hvs_t e;
        e = '0;
        for (int c = 0; c < hdc_dims_pkg::NUM_CLASSES; c++) begin
            for (int d = 0; d < hdc_dims_pkg::HV_DIM; d++) begin
                e[c][d] = (2 * ref_counts[c][d] > ref_samples[c]);
            end
        end
        return e;
    endfunction

    task automatic check_hvs(input class_hvs_t got, input class_hvs_t exp);
        for (int c = 0; c < hdc_dims_pkg::NUM_CLASSES; c++) begin
            if (got[c] !== exp[c]) begin
                value_errors++;
                $display("ERROR %0t bin_class_hvs[%0d]: got %h expected %h",
                         $time, c, got[c], exp[c]);
            end
        end
    endtask

    task automatic check_done(input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("ERROR %0t class_gen_done latency: got %0d expected %0d",
                     $time, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        nrst <= 1'b0;
        en <= 1'b1;
        start_class_gen <= 1'b0;
        training_dataset_finished <= 1'b0;
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        model_clear();
    endtask

    // negedge n is the edge n cycles after the strobe was sampled
    task automatic wait_done(input int limit, output int cycles);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            n++;
            seen = class_gen_done;
        end
        if (!seen) begin
            other_errors++;
            $display("class_gen_done did not arrive within %0d cycles at %0t", limit, $time);
        end
        cycles = n;
    endtask

    task automatic stall_en(input int delay, input int len);
        if (len > 0) begin
            repeat (delay) @(posedge clk);
            en <= 1'b0;
            repeat (len) @(posedge clk);
            en <= 1'b1;
        end
    endtask

    task automatic train_sample(input logic [hdc_dims_pkg::HV_DIM-1:0] hv, input int cls,
                                input int stall_at, input int stall_len);
        int latency;
        @(posedge clk);
        encoded_hv <= hv;
        class_select_bits <= cls[hdc_dims_pkg::CLASS_SEL_W-1:0];
        training_hdc_model <= 1'b1;
        start_class_gen <= 1'b1;
        @(posedge clk);
        start_class_gen <= 1'b0;
        fork
            wait_done(ACC_LATENCY + stall_len + 10, latency);
            stall_en(stall_at, stall_len);
        join
        model_bundle(hv, cls);
        check_done(latency, ACC_LATENCY + stall_len);
    endtask

    task automatic binarize_all(input int stall_at, input int stall_len);
        int latency;
        @(posedge clk);
        training_dataset_finished <= 1'b1;
        @(posedge clk);
        training_dataset_finished <= 1'b0;
        fork
            wait_done(BIN_LATENCY + stall_len + 10, latency);
            stall_en(stall_at, stall_len);
        join
        check_done(latency, BIN_LATENCY + stall_len);
        check_hvs(bin_class_hvs, expected_hvs());
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_hvs(bin_class_hvs, '0);
        if (class_gen_done !== 1'b0) begin
            other_errors++;
            $display("class_gen_done is not low after reset at %0t", $time);
        end
        binarize_all(0, 0);
    endtask

    task automatic test_accumulate_latency();
        logic seen;
        seen = 1'b0;
        train_sample(random_hv(), 0, 0, 0);
        train_sample(random_hv(), 0, 0, 0);
        // start outside training must be dropped
        @(posedge clk);
        training_hdc_model <= 1'b0;
        start_class_gen <= 1'b1;
        @(posedge clk);
        start_class_gen <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            seen = seen | class_gen_done;
        end
        if (seen) begin
            other_errors++;
            $display("class_gen_done came after a start with training_hdc_model low");
        end
        train_sample(random_hv(), 1, 0, 0);
    endtask

    task automatic test_majority();
        int n;
        for (int c = 0; c < hdc_dims_pkg::NUM_CLASSES; c++) begin
            n = 3 + ($unsigned($random(seed)) % 5);
            repeat (n) train_sample(random_hv(), c, 0, 0);
        end
        binarize_all(0, 0);
    endtask

    task automatic test_ties();
        logic [hdc_dims_pkg::HV_DIM-1:0] hv;
        apply_reset();
        hv = random_hv();
        train_sample(hv, 2, 0, 0);
        train_sample(~hv, 2, 0, 0);
        binarize_all(0, 0);
        if (bin_class_hvs[2] !== '0) begin
            value_errors++;
            $display("ERROR %0t bin_class_hvs[2]: got %h expected %h",
                     $time, bin_class_hvs[2], {hdc_dims_pkg::HV_DIM{1'b0}});
        end
    endtask

    task automatic test_stall();
        // a prior sample per class so extra counts during a stall flip bits
        train_sample(random_hv(), 1, 0, 0);
        train_sample(random_hv(), 3, 0, 0);
        train_sample(random_hv(), 1, 2, 3);
        train_sample(random_hv(), 3, 1, 2);
        binarize_all(6, 4);
    endtask

    initial begin
        clk = 1'b0;
        nrst = 1'b0;
        en = 1'b1;
        start_class_gen = 1'b0;
        training_hdc_model = 1'b0;
        training_dataset_finished = 1'b0;
        encoded_hv = '0;
        class_select_bits = '0;
        seed = 32'h9dd3_8b05;
        cycle_count = 0;
        value_errors = 0;
        other_errors = 0;

        apply_reset();
        test_reset_state();
        test_accumulate_latency();
        test_majority();
        test_ties();
        test_stall();

        @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/class_hv_gen_assert.sv */
`default_nettype none
`timescale 1ns/100ps

module class_hv_gen_assert (
    input wire       clk,
    input wire       nrst,
    input wire       en,
    input wire       class_gen_done,
    input wire       adjusting_nonbin_class_hvs,
    input wire       binarizing_class_hvs,
    input wire [1:0] state
);

    // done drops on the next active cycle
    done_single_cycle: assert property (
        @(posedge clk) disable iff (!nrst)
        (class_gen_done && en) |=> !class_gen_done
    ) else $error("class_gen_done held for more than one cycle");

    phases_exclusive: assert property (
        @(posedge clk) disable iff (!nrst)
        !(adjusting_nonbin_class_hvs && binarizing_class_hvs)
    ) else $error("accumulate and binarize phases active together");

    // stall freezes the FSM
    state_held_on_stall: assert property (
        @(posedge clk) disable iff (!nrst)
        !en |=> $stable(state)
    ) else $error("FSM state moved while en was low");

endmodule

bind class_fsm class_hv_gen_assert fsm_checks (
    .clk                        (clk),
    .nrst                       (nrst),
    .en                         (en),
    .class_gen_done             (class_gen_done),
    .adjusting_nonbin_class_hvs (adjusting_nonbin_class_hvs),
    .binarizing_class_hvs       (binarizing_class_hvs),
    .state                      (state)
);

`default_nettype wire

/* logic/class_hv_gen_top.sv */
`default_nettype none
`timescale 1ns/100ps

module class_hv_gen_top (
    input  wire  clk,
    input  wire  nrst,
    input  wire  en,
    input  wire  start_class_gen,
    input  wire  training_hdc_model,
    input  wire  training_dataset_finished,
    input  wire  [hdc_dims_pkg::HV_DIM-1:0] encoded_hv,
    input  wire  [hdc_dims_pkg::CLASS_SEL_W-1:0] class_select_bits,
    output logic [hdc_dims_pkg::NUM_CLASSES-1:0][hdc_dims_pkg::HV_DIM-1:0] bin_class_hvs,
    output logic class_gen_done
);

    // control path
    logic adjusting_nonbin_class_hvs;
    logic binarizing_class_hvs;
    logic ctr_clear;
    logic ctr_step;
    logic last_chunk;
    logic last_class;
    logic [class_gen_ctrl_pkg::CHUNK_CTR_W-1:0] chunk_ctr;
    logic [class_gen_ctrl_pkg::CLASS_CTR_W-1:0] class_ctr;

    // data path
    logic [hdc_dims_pkg::DIMS_PER_CC-1:0][hdc_dims_pkg::BITWIDTH_PER_DIM-1:0] nonbin_class_reg_out;
    logic [hdc_dims_pkg::DIMS_PER_CC-1:0][hdc_dims_pkg::BITWIDTH_PER_DIM-1:0] nonbin_class_reg_in;
    logic [hdc_dims_pkg::SAMPLE_CNT_W-1:0] sample_count;
    logic [hdc_dims_pkg::DIMS_PER_CC-1:0] bin_class_reg_in;

    class_fsm c_fsm (
        .clk                        (clk),
        .nrst                       (nrst),
        .en                         (en),
        .start_class_gen            (start_class_gen),
        .training_hdc_model         (training_hdc_model),
        .training_dataset_finished  (training_dataset_finished),
        .last_chunk                 (last_chunk),
        .last_class                 (last_class),
        .adjusting_nonbin_class_hvs (adjusting_nonbin_class_hvs),
        .binarizing_class_hvs       (binarizing_class_hvs),
        .ctr_clear                  (ctr_clear),
        .ctr_step                   (ctr_step),
        .class_gen_done             (class_gen_done)
    );

    chunk_class_counter c_ctr (
        .clk        (clk),
        .nrst       (nrst),
        .en         (en),
        .ctr_clear  (ctr_clear),
        .ctr_step   (ctr_step),
        .chunk_ctr  (chunk_ctr),
        .class_ctr  (class_ctr),
        .last_chunk (last_chunk),
        .last_class (last_class)
    );

    class_bundler c_bundle (
        .encoded_hv    (encoded_hv),
        .chunk_ctr     (chunk_ctr),
        .stored_counts (nonbin_class_reg_out),
        .sum           (nonbin_class_reg_in)
    );

    class_thresholder c_thr (
        .stored_counts     (nonbin_class_reg_out),
        .sample_count      (sample_count),
        .thresholded_chunk (bin_class_reg_in)
    );

    nonbinary_class_reg c_nonbin (
        .clk                        (clk),
        .nrst                       (nrst),
        .en                         (en),
        .adjusting_nonbin_class_hvs (adjusting_nonbin_class_hvs),
        .binarizing_class_hvs       (binarizing_class_hvs),
        .class_select_bits          (class_select_bits),
        .class_ctr                  (class_ctr),
        .chunk_ctr                  (chunk_ctr),
        .last_chunk                 (last_chunk),
        .nonbin_class_reg_in        (nonbin_class_reg_in),
        .nonbin_class_reg_out       (nonbin_class_reg_out),
        .sample_count               (sample_count)
    );

    binary_class_reg c_bin (
        .clk                  (clk),
        .nrst                 (nrst),
        .en                   (en),
        .binarizing_class_hvs (binarizing_class_hvs),
        .class_ctr            (class_ctr),
        .chunk_ctr            (chunk_ctr),
        .bin_class_reg_in     (bin_class_reg_in),
        .bin_class_hvs        (bin_class_hvs)
    );

endmodule

`default_nettype wire

/* logic/binary_class_reg.sv */
`default_nettype none
`timescale 1ns/100ps

module binary_class_reg (
    input  wire  clk,
    input  wire  nrst,
    input  wire  en,
    input  wire  binarizing_class_hvs,
    input  wire  [class_gen_ctrl_pkg::CLASS_CTR_W-1:0] class_ctr,
    input  wire  [class_gen_ctrl_pkg::CHUNK_CTR_W-1:0] chunk_ctr,
    input  wire  [hdc_dims_pkg::DIMS_PER_CC-1:0] bin_class_reg_in,
    output logic [hdc_dims_pkg::NUM_CLASSES-1:0][hdc_dims_pkg::HV_DIM-1:0] bin_class_hvs
);

    // chunk index maps onto the low-to-high slices of each class
    logic [hdc_dims_pkg::NUM_CLASSES-1:0]
          [hdc_dims_pkg::SEQ_CYCLE_COUNT-1:0]
          [hdc_dims_pkg::DIMS_PER_CC-1:0] bin_mem;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            bin_mem <= '0;
        end else if (en && binarizing_class_hvs) begin
            bin_mem[class_ctr][chunk_ctr] <= bin_class_reg_in;
        end
    end

    // whole memory visible at all times
    always_comb begin
        for (int c = 0; c < hdc_dims_pkg::NUM_CLASSES; c++) begin
            bin_class_hvs[c] = bin_mem[c];
        end
    end

endmodule

`default_nettype wire

/* logic/nonbinary_class_reg.sv */
`default_nettype none
`timescale 1ns/100ps

module nonbinary_class_reg (
    input  wire  clk,
    input  wire  nrst,
    input  wire  en,
    input  wire  adjusting_nonbin_class_hvs,
    input  wire  binarizing_class_hvs,
    input  wire  [hdc_dims_pkg::CLASS_SEL_W-1:0] class_select_bits,
    input  wire  [class_gen_ctrl_pkg::CLASS_CTR_W-1:0] class_ctr,
    input  wire  [class_gen_ctrl_pkg::CHUNK_CTR_W-1:0] chunk_ctr,
    input  wire  last_chunk,
    input  wire  [hdc_dims_pkg::DIMS_PER_CC-1:0][hdc_dims_pkg::BITWIDTH_PER_DIM-1:0]
                 nonbin_class_reg_in,
    output logic [hdc_dims_pkg::DIMS_PER_CC-1:0][hdc_dims_pkg::BITWIDTH_PER_DIM-1:0]
                 nonbin_class_reg_out,
    output logic [hdc_dims_pkg::SAMPLE_CNT_W-1:0] sample_count
);

    // counts per class, per chunk, per dimension
    logic [hdc_dims_pkg::NUM_CLASSES-1:0]
          [hdc_dims_pkg::SEQ_CYCLE_COUNT-1:0]
          [hdc_dims_pkg::DIMS_PER_CC-1:0]
          [hdc_dims_pkg::BITWIDTH_PER_DIM-1:0] class_counts;

    logic [hdc_dims_pkg::NUM_CLASSES-1:0][hdc_dims_pkg::SAMPLE_CNT_W-1:0] class_samples;

    logic [hdc_dims_pkg::CLASS_SEL_W-1:0] sel_class;

    // the binarize walk reads classes in order, training uses the given label
    assign sel_class = binarizing_class_hvs ? class_ctr : class_select_bits;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            class_counts  <= '0;
            class_samples <= '0;
        end else if (en && adjusting_nonbin_class_hvs) begin
            class_counts[sel_class][chunk_ctr] <= nonbin_class_reg_in;
            // one sample complete once its last chunk is bundled
            if (last_chunk &&
                (class_samples[sel_class] != hdc_dims_pkg::MAX_SAMPLE_COUNT)) begin
                class_samples[sel_class] <= class_samples[sel_class] + 1'b1;
            end
        end
    end

    assign nonbin_class_reg_out = class_counts[sel_class][chunk_ctr];
    assign sample_count         = class_samples[sel_class];

endmodule

`default_nettype wire

/* logic/class_thresholder.sv */
`default_nettype none
`timescale 1ns/100ps

module class_thresholder (
    input  wire  [hdc_dims_pkg::DIMS_PER_CC-1:0][hdc_dims_pkg::BITWIDTH_PER_DIM-1:0] stored_counts,
    input  wire  [hdc_dims_pkg::SAMPLE_CNT_W-1:0] sample_count,
    output logic [hdc_dims_pkg::DIMS_PER_CC-1:0] thresholded_chunk
);

    // one extra bit holds twice the count without overflow
    logic [hdc_dims_pkg::BITWIDTH_PER_DIM:0] twice_count;
    logic [hdc_dims_pkg::BITWIDTH_PER_DIM:0] samples_ext;

    always_comb begin
        samples_ext = '0;
        samples_ext[hdc_dims_pkg::SAMPLE_CNT_W-1:0] = sample_count;
        twice_count = '0;
        for (int i = 0; i < hdc_dims_pkg::DIMS_PER_CC; i++) begin
            twice_count = {stored_counts[i], 1'b0};
            // strict majority, so a tie gives zero
            thresholded_chunk[i] = (twice_count > samples_ext);
        end
    end

endmodule

`default_nettype wire

/* logic/class_bundler.sv */
`default_nettype none
`timescale 1ns/100ps

module class_bundler (
    input  wire  [hdc_dims_pkg::HV_DIM-1:0] encoded_hv,
    input  wire  [class_gen_ctrl_pkg::CHUNK_CTR_W-1:0] chunk_ctr,
    input  wire  [hdc_dims_pkg::DIMS_PER_CC-1:0][hdc_dims_pkg::BITWIDTH_PER_DIM-1:0] stored_counts,
    output logic [hdc_dims_pkg::DIMS_PER_CC-1:0][hdc_dims_pkg::BITWIDTH_PER_DIM-1:0] sum
);

    logic [hdc_dims_pkg::DIMS_PER_CC-1:0] hv_chunk;

    // chunk 0 is the low slice of the hypervector
    assign hv_chunk = encoded_hv[chunk_ctr*hdc_dims_pkg::DIMS_PER_CC +: hdc_dims_pkg::DIMS_PER_CC];

    always_comb begin
        for (int i = 0; i < hdc_dims_pkg::DIMS_PER_CC; i++) begin
            // count ones, holding at the top value
            if (hv_chunk[i] && (stored_counts[i] != hdc_dims_pkg::MAX_DIM_COUNT)) begin
                sum[i] = stored_counts[i] + 1'b1;
            end else begin
                sum[i] = stored_counts[i];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/chunk_class_counter.sv */
`default_nettype none
`timescale 1ns/100ps

module chunk_class_counter (
    input  wire  clk,
    input  wire  nrst,
    input  wire  en,
    input  wire  ctr_clear,
    input  wire  ctr_step,
    output logic [class_gen_ctrl_pkg::CHUNK_CTR_W-1:0] chunk_ctr,
    output logic [class_gen_ctrl_pkg::CLASS_CTR_W-1:0] class_ctr,
    output logic last_chunk,
    output logic last_class
);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            chunk_ctr <= '0;
            class_ctr <= '0;
        end else if (en) begin
            if (ctr_clear) begin
                chunk_ctr <= '0;
                class_ctr <= '0;
            end else if (ctr_step) begin
                if (last_chunk) begin
                    // chunk wraps, move on to the next class
                    chunk_ctr <= '0;
                    if (last_class) begin
                        class_ctr <= '0;
                    end else begin
                        class_ctr <= class_ctr + 1'b1;
                    end
                end else begin
                    chunk_ctr <= chunk_ctr + 1'b1;
                end
            end
        end
    end

    // terminal count flags for the FSM
    assign last_chunk = (chunk_ctr == class_gen_ctrl_pkg::LAST_CHUNK_IDX);
    assign last_class = (class_ctr == class_gen_ctrl_pkg::LAST_CLASS_CTR);

endmodule

`default_nettype wire

/* logic/class_fsm.sv */
`default_nettype none
`timescale 1ns/100ps

module class_fsm (
    input  wire  clk,
    input  wire  nrst,
    input  wire  en,
    input  wire  start_class_gen,
    input  wire  training_hdc_model,
    input  wire  training_dataset_finished,
    input  wire  last_chunk,
    input  wire  last_class,
    output logic adjusting_nonbin_class_hvs,
    output logic binarizing_class_hvs,
    output logic ctr_clear,
    output logic ctr_step,
    output logic class_gen_done
);

    class_gen_ctrl_pkg::class_gen_state_t state;
    class_gen_ctrl_pkg::class_gen_state_t next_state;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= class_gen_ctrl_pkg::IDLE;
        end else if (en) begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            class_gen_ctrl_pkg::IDLE: begin
                // start is only honoured while training
                if (start_class_gen && training_hdc_model) begin
                    next_state = class_gen_ctrl_pkg::ACCUMULATE;
                end else if (training_dataset_finished) begin
                    next_state = class_gen_ctrl_pkg::BINARIZE;
                end
            end
            class_gen_ctrl_pkg::ACCUMULATE: begin
                if (last_chunk) begin
                    next_state = class_gen_ctrl_pkg::DONE;
                end
            end
            class_gen_ctrl_pkg::BINARIZE: begin
                // class is the outer loop, chunk the inner one
                if (last_chunk && last_class) begin
                    next_state = class_gen_ctrl_pkg::DONE;
                end
            end
            default: begin
                next_state = class_gen_ctrl_pkg::IDLE;
            end
        endcase
    end

    // phase levels
    assign adjusting_nonbin_class_hvs = (state == class_gen_ctrl_pkg::ACCUMULATE);
    assign binarizing_class_hvs       = (state == class_gen_ctrl_pkg::BINARIZE);
    assign class_gen_done             = (state == class_gen_ctrl_pkg::DONE);

    // counters run during either phase and sit at zero otherwise
    assign ctr_step  = adjusting_nonbin_class_hvs || binarizing_class_hvs;
    assign ctr_clear = !ctr_step;

endmodule

`default_nettype wire

/* logic/class_gen_ctrl_pkg.sv */
`default_nettype none

package class_gen_ctrl_pkg;

    // controller phases
    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        ACCUMULATE = 2'b01,
        BINARIZE   = 2'b10,
        DONE       = 2'b11
    } class_gen_state_t;

    // chunk counter walks the chunks of one hypervector
    localparam int CHUNK_CTR_W = 2;

    // class counter walks the classes while binarizing
    localparam int CLASS_CTR_W = hdc_dims_pkg::CLASS_SEL_W;

    // terminal counter values, decoded once in the counter block
    localparam logic [CHUNK_CTR_W-1:0] LAST_CHUNK_IDX =
        CHUNK_CTR_W'(hdc_dims_pkg::SEQ_CYCLE_COUNT - 1);

    localparam logic [CLASS_CTR_W-1:0] LAST_CLASS_CTR =
        CLASS_CTR_W'(hdc_dims_pkg::NUM_CLASSES - 1);

endpackage

`default_nettype wire

/* logic/hdc_dims_pkg.sv */
`default_nettype none

package hdc_dims_pkg;

    // hypervector geometry
    localparam int HV_DIM          = 64;
    localparam int DIMS_PER_CC     = 16;
    localparam int SEQ_CYCLE_COUNT = HV_DIM / DIMS_PER_CC;

    // class space
    localparam int NUM_CLASSES = 4;
    localparam int CLASS_SEL_W = 2;

    // per-dimension count, saturating
    localparam int BITWIDTH_PER_DIM = 6;
    localparam logic [BITWIDTH_PER_DIM-1:0] MAX_DIM_COUNT = '1;

    // samples seen per class, also saturating
    localparam int SAMPLE_CNT_W = 6;
    localparam logic [SAMPLE_CNT_W-1:0] MAX_SAMPLE_COUNT = '1;

    // index of the last class number
    localparam logic [CLASS_SEL_W-1:0] LAST_CLASS_IDX = CLASS_SEL_W'(NUM_CLASSES - 1);

endpackage

`default_nettype wire
